/* Makefile */
# Verilator build and run for the signed divider

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BUILD_DIR)/V%: $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $* -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/div_config.svh */
// Divider configuration
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// operand width of every data word
`define DIV_WIDTH 32

// one quotient digit per step
`define DIV_STEPS `DIV_WIDTH

// edges from request acceptance to o_ack
// load, steps, quotient pass and remainder pass
`define DIV_LATENCY (`DIV_STEPS + 3)

`endif

/* common/div_pkg.sv */
// Divider shared types
`default_nettype none

`include "div_config.svh"

package div_pkg;

  // request word pair
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] dividend;
    logic [`DIV_WIDTH-1:0] divisor;
  } div_req_t;

  // result word pair
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] quotient;
    logic [`DIV_WIDTH-1:0] remainder;
  } div_rsp_t;

  // control phases
  typedef enum logic [2:0] {
    IDLE = 3'd0,
    LOAD = 3'd1,
    STEP = 3'd2,
    QUOT = 3'd3,
    REM  = 3'd4,
    DONE = 3'd5
  } div_phase_t;

  // propagate/generate pair of a bit or a bit group
  typedef struct packed {
    logic p;
    logic g;
  } pg_t;

  // black cell: merge upper group with lower group
  function automatic pg_t pg_black(input pg_t hi, input pg_t lo);
    pg_t res;
    res.p = hi.p & lo.p;
    res.g = hi.g | (hi.p & lo.g);
    return res;
  endfunction

  // grey cell: lower generate is already final
  function automatic logic pg_grey(input pg_t hi, input logic g_lo);
    return hi.g | (hi.p & g_lo);
  endfunction

endpackage

`default_nettype wire

/* hw/adder/prefix_adder.sv */
// Han-Carlson prefix adder
`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module prefix_adder (
  input  wire logic [`DIV_WIDTH-1:0] i_a,
  input  wire logic [`DIV_WIDTH-1:0] i_b,
  input  wire logic                  i_cin,
  output logic      [`DIV_WIDTH-1:0] o_sum,
  output logic                       o_cout
);

  import div_pkg::*;

  localparam int W      = `DIV_WIDTH;
  localparam int HALF   = W / 2;
  localparam int LEVELS = $clog2(W);

  pg_t        bit_pg [W];
  // odd-position tree, one node per bit pair
  pg_t        node   [LEVELS][HALF];
  logic       g0_cin;
  logic [W-1:0] carry;

  // bitwise propagate/generate
  for (genvar i = 0; i < W; i++) begin : g_bit
    assign bit_pg[i] = '{p: i_a[i] ^ i_b[i], g: i_a[i] & i_b[i]};
  end

  // carry in folded into bit zero
  assign g0_cin = pg_grey(bit_pg[0], i_cin);

  // first level pairs bit 2j+1 with bit 2j
  for (genvar j = 0; j < HALF; j++) begin : g_pair
    if (j == 0) begin : g_low
      assign node[0][j] = '{p: 1'b0, g: pg_grey(bit_pg[1], g0_cin)};
    end else begin : g_blk
      assign node[0][j] = pg_black(bit_pg[2*j+1], bit_pg[2*j]);
    end
  end

  // sparse tree over the pair nodes, distance doubles per level
  for (genvar k = 1; k < LEVELS; k++) begin : g_lvl
    localparam int D = 1 << (k - 1);
    for (genvar j = 0; j < HALF; j++) begin : g_node
      if (j >= 2 * D) begin : g_blk
        assign node[k][j] = pg_black(node[k-1][j], node[k-1][j-D]);
      end else if (j >= D) begin : g_gry
        // lower node already complete
        assign node[k][j] = '{p: 1'b0, g: pg_grey(node[k-1][j], node[k-1][j-D].g)};
      end else begin : g_pass
        assign node[k][j] = node[k-1][j];
      end
    end
  end

  // odd carries from the tree, even ones from a last grey level
  for (genvar j = 0; j < HALF; j++) begin : g_carry
    assign carry[2*j+1] = node[LEVELS-1][j].g;
    if (j == 0) begin : g_c0
      assign carry[0] = g0_cin;
    end else begin : g_ce
      assign carry[2*j] = pg_grey(bit_pg[2*j], node[LEVELS-1][j-1].g);
    end
  end

  // sum bits
  assign o_sum[0] = bit_pg[0].p ^ i_cin;
  for (genvar i = 1; i < W; i++) begin : g_sum
    assign o_sum[i] = bit_pg[i].p ^ carry[i-1];
  end

  assign o_cout = carry[W-1];

endmodule

`default_nettype wire

/* hw/div_top.sv */
// Signed divider top level
`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_top (
  input  wire logic              i_clk,
  input  wire logic              i_rst,
  input  wire logic              i_req,
  input  wire div_pkg::div_req_t i_op,
  output logic                   o_ack,
  output div_pkg::div_rsp_t      o_rsp
);

  import div_pkg::*;

  div_phase_t            phase;
  logic                  last;
  logic [`DIV_WIDTH-1:0] add_a;
  logic [`DIV_WIDTH-1:0] add_b;
  logic                  add_cin;
  logic [`DIV_WIDTH-1:0] sum;

  div_control div_control_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_req   (i_req),
    .o_ack   (o_ack),
    .o_phase (phase),
    .o_last  (last)
  );

  div_datapath div_datapath_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_phase   (phase),
    .i_last    (last),
    .i_op      (i_op),
    .i_sum     (sum),
    .o_add_a   (add_a),
    .o_add_b   (add_b),
    .o_add_cin (add_cin),
    .o_rsp     (o_rsp)
  );

  // shared by loop steps and both fix-up passes
  prefix_adder prefix_adder_i (
    .i_a    (add_a),
    .i_b    (add_b),
    .i_cin  (add_cin),
    .o_sum  (sum),
    .o_cout ()
  );

endmodule

`default_nettype wire

/* hw/divider/div_control.sv */
// Divider handshake and phase control
`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_control (
  input  wire logic               i_clk,
  input  wire logic               i_rst,
  input  wire logic               i_req,
  output logic                    o_ack,
  output div_pkg::div_phase_t     o_phase,
  output logic                    o_last
);

  import div_pkg::*;

  localparam int CW = $clog2(`DIV_STEPS);
  localparam logic [CW-1:0] LAST_CNT = CW'(`DIV_STEPS - 1);

  div_phase_t    phase;
  div_phase_t    phase_nxt;
  logic [CW-1:0] step_cnt;
  logic          last_step;

  assign last_step = (phase == STEP) && (step_cnt == LAST_CNT);

  // phase sequencing
  always_comb begin
    phase_nxt = phase;
    case (phase)
      IDLE: begin
        // ack is low in IDLE, so a request is taken right away
        if (i_req) begin
          phase_nxt = LOAD;
        end
      end
      LOAD: phase_nxt = STEP;
      STEP: begin
        if (last_step) begin
          phase_nxt = QUOT;
        end
      end
      QUOT: phase_nxt = REM;
      REM:  phase_nxt = DONE;
      DONE: begin
        // held here until the requester lets go
        if (!i_req) begin
          phase_nxt = IDLE;
        end
      end
      default: phase_nxt = IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      phase <= IDLE;
    end else begin
      phase <= phase_nxt;
    end
  end

  // step counter
  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      step_cnt <= '0;
    end else if (phase == LOAD) begin
      step_cnt <= '0;
    end else if (phase == STEP) begin
      step_cnt <= step_cnt + 1'b1;
    end
  end

  assign o_phase = phase;
  assign o_last  = last_step;
  assign o_ack   = (phase == DONE);

endmodule

`default_nettype wire

/* hw/divider/div_datapath.sv */
// Non-restoring divider datapath
`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_datapath (
  input  wire logic                  i_clk,
  input  wire logic                  i_rst,
  input  wire div_pkg::div_phase_t   i_phase,
  input  wire logic                  i_last,
  input  wire div_pkg::div_req_t     i_op,
  input  wire logic [`DIV_WIDTH-1:0] i_sum,
  output logic      [`DIV_WIDTH-1:0] o_add_a,
  output logic      [`DIV_WIDTH-1:0] o_add_b,
  output logic                       o_add_cin,
  output div_pkg::div_rsp_t          o_rsp
);

  import div_pkg::*;

  localparam int W = `DIV_WIDTH;

  logic [W-1:0] rem;
  logic [W-1:0] dvd_sh;
  logic [W-1:0] dvs;
  logic [W-1:0] q_pos;
  logic [W-1:0] q_neg;
  logic         dvd_sign;
  logic         fix;
  logic         fix_add;
  logic         nsub;
  logic [W-1:0] rem_shift;
  logic         fin_wrong_sign;
  logic         fin_full;

  // add the divisor when remainder and divisor signs differ
  assign nsub      = rem[W-1] ^ dvs[W-1];
  assign rem_shift = {rem[W-2:0], dvd_sh[W-1]};

  // final remainder checks, taken from the last step's sum
  assign fin_wrong_sign = (|i_sum) && (i_sum[W-1] != dvd_sign);
  // remainder can land on -|divisor| in exact divisions
  assign fin_full = dvs[W-1] ? (i_sum == dvs) : (i_sum == -dvs);

  // adder operand selection
  always_comb begin
    o_add_a   = '0;
    o_add_b   = '0;
    o_add_cin = 1'b0;
    case (i_phase)
      STEP: begin
        o_add_a   = rem_shift;
        o_add_b   = nsub ? dvs : ~dvs;
        o_add_cin = ~nsub;
      end
      QUOT: begin
        // q_pos - q_neg, one more where the last step over-subtracted
        o_add_a   = (fix && !fix_add) ? q_pos + 1'b1 : q_pos;
        o_add_b   = ~q_neg;
        o_add_cin = !(fix && fix_add);
      end
      REM: begin
        o_add_a   = rem;
        o_add_b   = fix ? (fix_add ? dvs : ~dvs) : '0;
        o_add_cin = fix && !fix_add;
      end
      default: begin
        o_add_a   = '0;
        o_add_b   = '0;
        o_add_cin = 1'b0;
      end
    endcase
  end

  // partial remainder and digit registers
  always_ff @(posedge i_clk) begin
    case (i_phase)
      LOAD: begin
        dvs      <= i_op.divisor;
        dvd_sign <= i_op.dividend[W-1];
        dvd_sh   <= i_op.dividend;
        rem      <= {W{i_op.dividend[W-1]}};
      end
      STEP: begin
        rem    <= i_sum;
        dvd_sh <= {dvd_sh[W-2:0], 1'b0};
        q_pos  <= {q_pos[W-2:0], ~nsub};
        q_neg  <= {q_neg[W-2:0], nsub};
        if (i_last) begin
          fix     <= fin_wrong_sign || fin_full;
          fix_add <= i_sum[W-1] ^ dvs[W-1];
        end
      end
      default: begin
      end
    endcase
  end

  // result registers
  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      o_rsp <= '0;
    end else if (i_phase == QUOT) begin
      o_rsp.quotient <= i_sum;
    end else if (i_phase == REM) begin
      o_rsp.remainder <= i_sum;
    end
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
common/div_pkg.sv
hw/adder/prefix_adder.sv
hw/divider/div_control.sv
hw/divider/div_datapath.sv
hw/div_top.sv
test/div_assert.sv
test/div_tb.sv

/* test/div_assert.sv */
// Divider handshake assertions
`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_assert (
  input wire logic                i_clk,
  input wire logic                i_rst,
  input wire logic                i_req,
  input wire div_pkg::div_phase_t i_phase,
  input wire logic                i_ack,
  input wire div_pkg::div_rsp_t   i_rsp
);

  import div_pkg::*;

  int   fail_cnt;
  logic accept;

  initial fail_cnt = 0;

  // request taken from IDLE
  assign accept = (i_phase == IDLE) && i_req;

  // outputs cleared while reset is held
  reset_quiet: assert property (@(posedge i_clk) !i_rst |-> (!i_ack && i_rsp == '0))
    else begin
      fail_cnt++;
      $error("o_ack or o_rsp not cleared during reset");
    end

  // ack rises a fixed number of edges after acceptance, never earlier
  ack_on_time: assert property (@(posedge i_clk) disable iff (!i_rst)
    $past(accept, `DIV_LATENCY + 1) |-> $rose(i_ack))
    else begin
      fail_cnt++;
      $error("o_ack did not rise at the expected latency");
    end

  ack_not_early: assert property (@(posedge i_clk) disable iff (!i_rst)
    $rose(i_ack) |-> $past(accept, `DIV_LATENCY + 1))
    else begin
      fail_cnt++;
      $error("o_ack rose without a request at the expected distance");
    end

  // result frozen while acknowledged
  rsp_stable: assert property (@(posedge i_clk) disable iff (!i_rst)
    i_ack |=> $stable(i_rsp))
    else begin
      fail_cnt++;
      $error("o_rsp changed while o_ack was high");
    end

  ack_release: assert property (@(posedge i_clk) disable iff (!i_rst)
    (i_ack && !i_req) |=> !i_ack)
    else begin
      fail_cnt++;
      $error("o_ack stayed high after i_req was dropped");
    end

  // back-pressure keeps the divider in DONE
  ack_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
    (i_ack && i_req) |=> i_ack)
    else begin
      fail_cnt++;
      $error("o_ack fell while i_req was still high");
    end

endmodule

`default_nettype wire

/* test/div_tb.sv */
// Signed divider testbench
`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_tb;

  import div_pkg::*;

  localparam int W           = `DIV_WIDTH;
  localparam int CLK_PERIOD  = 100;
  localparam int N_DIRECTED  = 20;
  localparam int N_RANDOM    = 200;
  localparam int N_HANDSHAKE = 4;
  localparam int N_OPS       = N_DIRECTED + N_RANDOM + N_HANDSHAKE;
  localparam int ACK_LIMIT   = `DIV_LATENCY + 4;
  // per operation latency plus drive, release and a few held cycles
  localparam longint WATCHDOG_NS =
    longint'(N_OPS * (`DIV_LATENCY + 6) + 100) * CLK_PERIOD;

  logic     i_clk;
  logic     i_rst;
  logic     i_req;
  div_req_t i_op;
  logic     o_ack;
  div_rsp_t o_rsp;

  int errors;
  int ops;
  int tests;

  div_top div_top_i (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_req (i_req),
    .i_op  (i_op),
    .o_ack (o_ack),
    .o_rsp (o_rsp)
  );

  bind div_top div_assert div_assert_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_req   (i_req),
    .i_phase (phase),
    .i_ack   (o_ack),
    .i_rsp   (o_rsp)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  task automatic check_word(input string name, input logic [W-1:0] exp,
                            input logic [W-1:0] act);
    assert (act == exp) else begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_mark, input int op_mark);
    tests++;
    $display("test %-10s %0d operations, %0d errors", name, ops - op_mark,
             errors - err_mark);
  endtask

  // one full four-phase transaction started on a falling edge
  task automatic run_div(input logic signed [W-1:0] dvd, input logic signed [W-1:0] dvs,
                         input int hold);
    logic signed [W-1:0] exp_q;
    logic signed [W-1:0] exp_r;
    int                  wait_cnt;
    // native division truncates toward zero and keeps the dividend sign
    exp_q = dvd / dvs;
    exp_r = dvd % dvs;
    ops++;
    i_op.dividend = dvd;
    i_op.divisor  = dvs;
    i_req         = 1'b1;
    wait_cnt      = 0;
    while (!o_ack && wait_cnt < ACK_LIMIT) begin
      @(negedge i_clk);
      wait_cnt++;
    end
    if (!o_ack) begin
      $display("no acknowledge for %h / %h within %0d cycles", dvd, dvs, ACK_LIMIT);
      errors++;
    end else begin
      check_word("o_rsp.quotient", exp_q, o_rsp.quotient);
      check_word("o_rsp.remainder", exp_r, o_rsp.remainder);
      if (hold > 0) begin
        repeat (hold) @(negedge i_clk);
        // held request must not disturb the result
        check_word("o_rsp.quotient", exp_q, o_rsp.quotient);
        check_word("o_rsp.remainder", exp_r, o_rsp.remainder);
      end
    end
    i_req    = 1'b0;
    wait_cnt = 0;
    while (o_ack && wait_cnt < ACK_LIMIT) begin
      @(negedge i_clk);
      wait_cnt++;
    end
    if (o_ack) begin
      $display("o_ack stayed high after the request was dropped");
      errors++;
    end
  endtask

  initial begin
    int                  err_mark;
    int                  op_mark;
    int                  shamt;
    logic signed [W-1:0] dvd;
    logic signed [W-1:0] dvs;

    void'($urandom(32'h34b3_3494));
    errors = 0;
    ops    = 0;
    tests  = 0;
    i_rst  = 1'b0;
    i_req  = 1'b0;
    i_op   = '0;

    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    err_mark = errors;
    op_mark  = ops;
    check_word("o_ack", W'(1'b0), W'(o_ack));
    check_word("o_rsp.quotient", '0, o_rsp.quotient);
    check_word("o_rsp.remainder", '0, o_rsp.remainder);
    i_rst = 1'b1;
    @(negedge i_clk);
    check_word("o_ack", W'(1'b0), W'(o_ack));
    check_word("o_rsp.quotient", '0, o_rsp.quotient);
    check_word("o_rsp.remainder", '0, o_rsp.remainder);
    report_test("reset", err_mark, op_mark);

    err_mark = errors;
    op_mark  = ops;
    run_div(100, 7, 0);
    run_div(100, 10, 0);
    run_div(12345, 1, 0);
    run_div(0, 5, 0);
    run_div(7, 9, 0);
    run_div(32'h7fff_ffff, 1, 0);
    run_div(32'h7fff_ffff, 32'h7fff_ffff, 0);
    run_div(1000000, 1000, 0);
    report_test("positive", err_mark, op_mark);

    err_mark = errors;
    op_mark  = ops;
    run_div(-100, 7, 0);
    run_div(100, -7, 0);
    run_div(-100, -7, 0);
    run_div(-100, 10, 0);
    run_div(100, -10, 0);
    run_div(-1, 7, 0);
    run_div(32'h8000_0000, 2, 0);
    run_div(32'h8000_0000, 7, 0);
    run_div(32'h7fff_ffff, -1, 0);
    // most negative divisor
    run_div(5, 32'h8000_0000, 0);
    run_div(-5, 32'h8000_0000, 0);
    run_div(32'h8000_0000, 32'h8000_0000, 0);
    report_test("signed", err_mark, op_mark);

    err_mark = errors;
    op_mark  = ops;
    for (int n = 0; n < N_RANDOM; n++) begin
      dvd   = $urandom;
      dvs   = $urandom;
      shamt = $urandom_range(31, 0);
      // spread divisor magnitudes for long and short quotients
      dvs = dvs >>> shamt;
      if (dvs == 0) begin
        dvs = 1;
      end
      if (dvd == 32'h8000_0000 && dvs == -1) begin
        dvs = 3;
      end
      run_div(dvd, dvs, 0);
    end
    report_test("random", err_mark, op_mark);

    err_mark = errors;
    op_mark  = ops;
    run_div(1000, 3, 3);
    run_div(-77, 5, 1);
    run_div(123456789, -321, 5);
    run_div(-9, -2, 0);
    report_test("handshake", err_mark, op_mark);

    $display("summary: %0d tests, %0d operations, %0d check errors, %0d assertion errors",
             tests, ops, errors, div_top_i.div_assert_i.fail_cnt);
    if (errors == 0 && div_top_i.div_assert_i.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
